// ==== Bender.yml ====
package:
  name: machine_trap_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/csr_pkg.sv
      - common/trap_if.sv
      - common/csr_state_if.sv
      - csr_file/csr_file.sv
      - source/trap_arbiter.sv
      - source/trap_redirect.sv
      - source/machine_trap_unit.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - tb/tb_machine_trap_unit.sv

// ==== common/core_params.svh ====
// core-wide pc geometry and hart identity for the trap unit
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// stored pc bits above the always-zero low bits
`define CORE_PC_LEN 30

// low pc bits that are always zero
`define CORE_PC_ZEROS 2

// value returned by mhartid
`define CORE_HART_ID 32'h0000_0000

`endif

// ==== common/csr_pkg.sv ====
// machine-mode CSR types, address field encodings and padding helpers shared by the trap unit
`include "core_params.svh"

package csr_pkg;

  // privilege field, csr address bits 9:8
  typedef enum logic [1:0] {
    PRIV_USER       = 2'b00,
    PRIV_SUPERVISOR = 2'b01,
    PRIV_HYPERVISOR = 2'b10,
    PRIV_MACHINE    = 2'b11
  } privilege_e;

  // access mode, csr address bits 11:10
  typedef enum logic [1:0] {
    ACC_NORMAL   = 2'b00,
    ACC_COUNTER  = 2'b10,
    ACC_READONLY = 2'b11
  } access_mode_e;

  // only mie and mpie are live, rest reads zero
  typedef struct packed {
    logic [23:0] rsvd_hi;
    logic        mpie;
    logic [2:0]  rsvd_mid;
    logic        mie;
    logic [2:0]  rsvd_lo;
  } mstatus_t;

  // enable bits, external / timer / software
  typedef struct packed {
    logic meie;
    logic mtie;
    logic msie;
  } mie_m_only_t;

  // pending bits, same order as the enables
  typedef struct packed {
    logic meip;
    logic mtip;
    logic msip;
  } mip_m_only_t;

  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;
  } mtvec_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] code;
  } mcause_t;

  // mode 0 is direct, only other legal value
  localparam logic [1:0] MTVEC_MODE_VECTORED = 2'b01;

  // interrupt cause codes
  localparam logic [30:0] CAUSE_M_SOFTWARE_INT = 31'd3;
  localparam logic [30:0] CAUSE_M_TIMER_INT    = 31'd7;
  localparam logic [30:0] CAUSE_M_EXTERN_INT   = 31'd11;

  // spread ext/timer/sw onto bits 11/7/3
  function automatic logic [31:0] pad_mie_mip(input logic [2:0] bits);
    logic [31:0] word;
    word     = '0;
    word[11] = bits[2];
    word[7]  = bits[1];
    word[3]  = bits[0];
    return word;
  endfunction

  // stored pc back to a full byte address
  function automatic logic [31:0] pad_pc(input logic [`CORE_PC_LEN-1:0] pc);
    return {pc, {`CORE_PC_ZEROS{1'b0}}};
  endfunction

endpackage

// ==== common/csr_state_if.sv ====
// live machine-mode CSR state from the CSR file to the arbiter and redirect stage
`timescale 1ns/100ps
`include "core_params.svh"

interface csr_state_if;
  import csr_pkg::*;

  mstatus_t                mstatus;
  mie_m_only_t             mie;
  // raw interrupt levels
  mip_m_only_t             mip;
  mtvec_t                  mtvec;
  logic [`CORE_PC_LEN-1:0] mepc;

  modport source (output mstatus, mie, mip, mtvec, mepc);

  // enable rule and pending set
  modport arbiter (input mstatus, mie, mip);

  // vector base and return target
  modport redirect (input mtvec, mepc);

endinterface

// ==== common/trap_if.sv ====
// trap and return decision from the arbiter to the CSR file and redirect stage
`timescale 1ns/100ps
`include "core_params.svh"

interface trap_if;
  import csr_pkg::*;

  // one-cycle strobes, never both high
  logic                    trap_occurred;
  logic                    trap_returned;
  // saved pc and cause on trap entry
  logic [`CORE_PC_LEN-1:0] new_mepc;
  mcause_t                 new_mcause;

  modport arbiter (output trap_occurred, trap_returned, new_mepc, new_mcause);

  modport csr_file (input trap_occurred, trap_returned, new_mepc, new_mcause);

  // redirect needs no epc, target comes from mtvec or mepc
  modport redirect (input trap_occurred, trap_returned, new_mcause);

endinterface

// ==== csr_file/csr_file.sv ====
// machine-mode CSR file with read mux, software writes, trap entry/exit updates and cycle counter
`timescale 1ns/100ps
`include "core_params.svh"

module csr_file (
  input  logic                 clk,
  input  logic                 rst_sync,
  input  logic                 stall_n,
  input  logic                 csr_wen,
  input  logic [11:0]          csr_addr,
  input  logic [31:0]          csr_wdata,
  output logic [31:0]          csr_rdata,
  input  logic                 mextern_int,
  input  logic                 mtimer_int,
  input  logic                 msoftware_int,
  trap_if.csr_file             trap,
  csr_state_if.source          state
);
  import csr_pkg::*;

  // short addresses, machine read-write space
  localparam logic [7:0] ADDR_MSTATUS  = 8'h00;
  localparam logic [7:0] ADDR_MIE      = 8'h04;
  localparam logic [7:0] ADDR_MTVEC    = 8'h05;
  localparam logic [7:0] ADDR_MSCRATCH = 8'h40;
  localparam logic [7:0] ADDR_MEPC     = 8'h41;
  localparam logic [7:0] ADDR_MCAUSE   = 8'h42;
  localparam logic [7:0] ADDR_MIP      = 8'h44;
  // read-only space
  localparam logic [7:0] ADDR_MHARTID  = 8'h14;
  // counter space
  localparam logic [7:0] ADDR_MCYCLE   = 8'h00;
  localparam logic [7:0] ADDR_MCYCLEH  = 8'h80;

  access_mode_e            rw_mode;
  privilege_e              priv;
  logic [7:0]              short_addr;
  logic                    sw_wen;

  mstatus_t                mstatus;
  mie_m_only_t             mie;
  mip_m_only_t             mip;
  mtvec_t                  mtvec;
  logic [31:0]             mscratch;
  logic [`CORE_PC_LEN-1:0] mepc;
  mcause_t                 mcause;
  logic [63:0]             mcycle_all;

  mstatus_t                mstatus_wr;
  mtvec_t                  mtvec_wr;

  // address split
  assign rw_mode    = access_mode_e'(csr_addr[11:10]);
  assign priv       = privilege_e'(csr_addr[9:8]);
  assign short_addr = csr_addr[7:0];

  // only machine read-write space is writable
  assign sw_wen = csr_wen && stall_n && (priv == PRIV_MACHINE) && (rw_mode == ACC_NORMAL);

  // pending bits follow the levels directly
  assign mip = {mextern_int, mtimer_int, msoftware_int};

  // live state out to arbiter and redirect
  assign state.mstatus = mstatus;
  assign state.mie     = mie;
  assign state.mip     = mip;
  assign state.mtvec   = mtvec;
  assign state.mepc    = mepc;

  // legal fields of software writes
  always_comb begin
    mstatus_wr      = '0;
    mstatus_wr.mie  = csr_wdata[3];
    mstatus_wr.mpie = csr_wdata[7];
    mtvec_wr        = csr_wdata;
    // mode 2 and 3 reserved, fold onto direct/vectored
    mtvec_wr.mode   = {1'b0, csr_wdata[0]};
  end

  // free-running cycle count
  always_ff @(posedge clk) begin
    if (rst_sync) begin
      mcycle_all <= '0;
    end else begin
      mcycle_all <= mcycle_all + 64'd1;
    end
  end

  // read mux
  always_comb begin
    csr_rdata = '0;
    if (priv == PRIV_MACHINE) begin
      case (rw_mode)
        ACC_READONLY: begin
          if (short_addr == ADDR_MHARTID) begin
            csr_rdata = `CORE_HART_ID;
          end
        end
        ACC_COUNTER: begin
          case (short_addr)
            ADDR_MCYCLE:  csr_rdata = mcycle_all[31:0];
            ADDR_MCYCLEH: csr_rdata = mcycle_all[63:32];
            default:      csr_rdata = '0;
          endcase
        end
        ACC_NORMAL: begin
          case (short_addr)
            ADDR_MSTATUS:  csr_rdata = mstatus;
            ADDR_MIE:      csr_rdata = pad_mie_mip(mie);
            ADDR_MTVEC:    csr_rdata = mtvec;
            ADDR_MSCRATCH: csr_rdata = mscratch;
            ADDR_MEPC:     csr_rdata = pad_pc(mepc);
            ADDR_MCAUSE:   csr_rdata = mcause;
            ADDR_MIP:      csr_rdata = pad_mie_mip(mip);
            default:       csr_rdata = '0;
          endcase
        end
        // 2'b01 space unimplemented
        default: csr_rdata = '0;
      endcase
    end
  end

  // control registers
  always_ff @(posedge clk) begin
    if (rst_sync) begin
      mstatus <= '0;
      mie     <= '0;
      mtvec   <= '0;
    end else if (sw_wen) begin
      // software write beats a same-cycle trap
      case (short_addr)
        ADDR_MSTATUS: mstatus <= mstatus_wr;
        ADDR_MIE:     mie <= {csr_wdata[11], csr_wdata[7], csr_wdata[3]};
        ADDR_MTVEC:   mtvec <= mtvec_wr;
        default:      ;
      endcase
    end else if (trap.trap_occurred) begin
      // stack the enable and mask further interrupts
      mstatus.mpie <= mstatus.mie;
      mstatus.mie  <= 1'b0;
    end else if (trap.trap_returned) begin
      mstatus.mie  <= mstatus.mpie;
      mstatus.mpie <= 1'b1;
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (sw_wen) begin
      case (short_addr)
        ADDR_MSCRATCH: mscratch <= csr_wdata;
        // ecall handlers step mepc past the call
        ADDR_MEPC:     mepc <= csr_wdata[31:`CORE_PC_ZEROS];
        // mcause has no software write path
        default:       ;
      endcase
    end else if (trap.trap_occurred) begin
      mepc   <= trap.new_mepc;
      mcause <= trap.new_mcause;
    end
  end

endmodule

// ==== machine_trap_unit.f ====
+incdir+common
common/csr_pkg.sv
common/trap_if.sv
common/csr_state_if.sv
csr_file/csr_file.sv
source/trap_arbiter.sv
source/trap_redirect.sv
source/machine_trap_unit.sv
tb/tb_machine_trap_unit.sv

// ==== source/machine_trap_unit.sv ====
// machine-mode trap unit joining CSR file, trap arbiter and redirect stage
`timescale 1ns/100ps
`include "core_params.svh"

module machine_trap_unit (
  input  logic                    clk,
  input  logic                    rst_sync,
  // csr access port
  input  logic                    csr_ren,
  input  logic                    csr_wen,
  input  logic [11:0]             csr_addr,
  input  logic [31:0]             csr_wdata,
  output logic [31:0]             csr_rdata,
  input  logic                    stall_n,
  // synchronous exception
  input  logic                    exc_valid,
  input  csr_pkg::mcause_t        exc_cause,
  input  logic [`CORE_PC_LEN-1:0] exc_pc,
  input  logic                    mret,
  // interrupt levels
  input  logic                    mextern_int,
  input  logic                    mtimer_int,
  input  logic                    msoftware_int,
  // fetch redirect
  output logic                    redirect_valid,
  output logic [31:0]             redirect_pc
);

  logic [31:0] csr_rdata_raw;

  trap_if      trap_bus ();
  csr_state_if state_bus ();

  // read data qualified by the read strobe
  assign csr_rdata = csr_ren ? csr_rdata_raw : 32'b0;

  csr_file csr_file_i (
    .clk           (clk),
    .rst_sync      (rst_sync),
    .stall_n       (stall_n),
    .csr_wen       (csr_wen),
    .csr_addr      (csr_addr),
    .csr_wdata     (csr_wdata),
    .csr_rdata     (csr_rdata_raw),
    .mextern_int   (mextern_int),
    .mtimer_int    (mtimer_int),
    .msoftware_int (msoftware_int),
    .trap          (trap_bus.csr_file),
    .state         (state_bus.source)
  );

  // combinational decision in the event cycle
  trap_arbiter trap_arbiter_i (
    .exc_valid (exc_valid),
    .exc_cause (exc_cause),
    .exc_pc    (exc_pc),
    .mret      (mret),
    .stall_n   (stall_n),
    .csr_wen   (csr_wen),
    .state     (state_bus.arbiter),
    .trap      (trap_bus.arbiter)
  );

  // redirect one cycle later
  trap_redirect trap_redirect_i (
    .clk            (clk),
    .rst_sync       (rst_sync),
    .trap           (trap_bus.redirect),
    .state          (state_bus.redirect),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

endmodule

// ==== source/trap_arbiter.sv ====
// trap arbiter ranking exceptions, mret and enabled pending interrupts into trap strobes
`timescale 1ns/100ps
`include "core_params.svh"

module trap_arbiter (
  input  logic                    exc_valid,
  input  csr_pkg::mcause_t        exc_cause,
  input  logic [`CORE_PC_LEN-1:0] exc_pc,
  input  logic                    mret,
  input  logic                    stall_n,
  input  logic                    csr_wen,
  csr_state_if.arbiter            state,
  trap_if.arbiter                 trap
);
  import csr_pkg::*;

  mip_m_only_t pend_en;
  logic        int_allowed;
  logic        int_take;

  // pending and enabled
  assign pend_en = mip_m_only_t'(state.mip & state.mie);

  // global enable, no stall, no csr write in flight
  assign int_allowed = state.mstatus.mie && stall_n && !csr_wen;
  assign int_take    = int_allowed && (|pend_en);

  always_comb begin
    trap.trap_occurred = 1'b0;
    trap.trap_returned = 1'b0;
    // interrupts resume at the current pc
    trap.new_mepc      = exc_pc;
    trap.new_mcause    = exc_cause;

    if (exc_valid) begin
      // exceptions win, also over mret
      trap.trap_occurred = 1'b1;
    end else if (mret) begin
      trap.trap_returned = 1'b1;
    end else if (int_take) begin
      trap.trap_occurred        = 1'b1;
      trap.new_mcause.interrupt = 1'b1;
      // external, then software, then timer
      if (pend_en.meip) begin
        trap.new_mcause.code = CAUSE_M_EXTERN_INT;
      end else if (pend_en.msip) begin
        trap.new_mcause.code = CAUSE_M_SOFTWARE_INT;
      end else begin
        trap.new_mcause.code = CAUSE_M_TIMER_INT;
      end
    end
  end

endmodule

// ==== source/trap_redirect.sv ====
// registered fetch redirect to the trap vector or the saved exception pc
`timescale 1ns/100ps
`include "core_params.svh"

module trap_redirect (
  input  logic          clk,
  input  logic          rst_sync,
  trap_if.redirect      trap,
  csr_state_if.redirect state,
  output logic          redirect_valid,
  output logic [31:0]   redirect_pc
);
  import csr_pkg::*;

  logic [31:0] trap_target;

  // base, plus 4*code for vectored interrupts
  always_comb begin
    trap_target = {state.mtvec.base, 2'b00};
    if ((state.mtvec.mode == MTVEC_MODE_VECTORED) && trap.new_mcause.interrupt) begin
      trap_target = trap_target + {trap.new_mcause.code[29:0], 2'b00};
    end
  end

  // one-cycle pulse after either strobe
  always_ff @(posedge clk) begin
    if (rst_sync) begin
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= trap.trap_occurred || trap.trap_returned;
    end
  end

  // target held until the next pulse
  always_ff @(posedge clk) begin
    if (trap.trap_occurred) begin
      redirect_pc <= trap_target;
    end else if (trap.trap_returned) begin
      redirect_pc <= pad_pc(state.mepc);
    end
  end

endmodule

// ==== tb/tb_machine_trap_unit.sv ====
// testbench for the machine-mode trap unit, random stimulus checked against a reference model
`timescale 1ns/100ps
`include "core_params.svh"

module tb_machine_trap_unit;

  localparam int REDIRECT_TIMEOUT = 8;

  logic                    clk = 1'b0;
  logic                    rst_sync;
  logic                    csr_ren;
  logic                    csr_wen;
  logic [11:0]             csr_addr;
  logic [31:0]             csr_wdata;
  logic [31:0]             csr_rdata;
  logic                    stall_n;
  logic                    exc_valid;
  logic [31:0]             exc_cause;
  logic [`CORE_PC_LEN-1:0] exc_pc;
  logic                    mret;
  logic                    mextern_int;
  logic                    mtimer_int;
  logic                    msoftware_int;
  logic                    redirect_valid;
  logic [31:0]             redirect_pc;

  // reference model state
  logic                    m_mstatus_mie;
  logic                    m_mpie;
  logic [2:0]              m_mie;
  logic [29:0]             m_mtvec_base;
  logic [1:0]              m_mtvec_mode;
  logic [31:0]             m_mscratch;
  logic [`CORE_PC_LEN-1:0] m_mepc;
  logic [31:0]             m_mcause;
  logic                    m_mcause_known;
  logic [63:0]             cycle_model;
  // redirect expected after the next edge
  logic                    exp_rv;
  logic [31:0]             exp_rpc;
  logic [31:0]             last_rdata;
  int                      checks;
  int                      errors;
  int                      timeouts;

  machine_trap_unit dut_i (.*);

  always #20 clk = ~clk;

  // cycle count from zero after reset
  always @(posedge clk) begin
    if (rst_sync) begin
      cycle_model <= 64'd0;
    end else begin
      cycle_model <= cycle_model + 64'd1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL at %0t %s expected %h actual %h", $time, name, exp, got);
    end
  endtask

  // ext/timer/sw onto bits 11/7/3
  function automatic logic [31:0] enable_word(input logic [2:0] b);
    return {20'h0, b[2], 3'b0, b[1], 3'b0, b[0], 3'b0};
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] a);
    case (a)
      12'h300: return {24'h0, m_mpie, 3'b0, m_mstatus_mie, 3'b0};
      12'h304: return enable_word(m_mie);
      12'h305: return {m_mtvec_base, m_mtvec_mode};
      12'h340: return m_mscratch;
      12'h341: return {m_mepc, 2'b00};
      12'h342: return m_mcause;
      12'h344: return enable_word({mextern_int, mtimer_int, msoftware_int});
      12'hB00: return cycle_model[31:0];
      12'hB80: return cycle_model[63:32];
      // mhartid, illegal privilege and holes all read zero
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [`CORE_PC_LEN-1:0] random_pc();
    logic [31:0] r;
    r = $urandom();
    return r[31:`CORE_PC_ZEROS];
  endfunction

  // known CSRs, lower privileges, unimplemented space and raw addresses
  function automatic logic [11:0] pick_addr();
    logic [31:0] r;
    r = $urandom();
    case ($urandom_range(0, 13))
      0:  return 12'h300;
      1:  return 12'h304;
      2:  return 12'h305;
      3:  return 12'h340;
      4:  return 12'h341;
      5:  return 12'h342;
      6:  return 12'h344;
      7:  return 12'hB00;
      8:  return 12'hB80;
      9:  return 12'hF14;
      10: return {4'b0001, r[7:0]};
      11: return {4'b0111, r[7:0]};
      default: return r[11:0];
    endcase
  endfunction

  task automatic set_idle();
    csr_ren   = 1'b0;
    csr_wen   = 1'b0;
    stall_n   = 1'b1;
    exc_valid = 1'b0;
    mret      = 1'b0;
  endtask

  // one clock from a falling edge to the next, inputs already driven
  task automatic run_cycle();
    logic        sw_wen;
    logic [2:0]  pend;
    logic        take_trap;
    logic        take_ret;
    logic [31:0] cause;
    // outcome of the previous cycle
    check_value("redirect_valid", redirect_valid, exp_rv);
    if (exp_rv) begin
      check_value("redirect_pc", redirect_pc, exp_rpc);
    end
    #5;
    last_rdata = csr_rdata;
    if (!(csr_ren && csr_addr == 12'h342 && !m_mcause_known)) begin
      check_value("csr_rdata", csr_rdata, csr_ren ? model_read(csr_addr) : 32'h0);
    end
    sw_wen    = csr_wen && stall_n && (csr_addr[11:8] == 4'b0011);
    pend      = {mextern_int, mtimer_int, msoftware_int} & m_mie;
    take_trap = 1'b0;
    take_ret  = 1'b0;
    cause     = exc_cause;
    if (exc_valid) begin
      take_trap = 1'b1;
    end else if (mret) begin
      take_ret = 1'b1;
    end else if (m_mstatus_mie && stall_n && !csr_wen && pend != 3'b000) begin
      take_trap = 1'b1;
      // priority external, software, timer
      cause = pend[2] ? 32'h8000_000B : (pend[0] ? 32'h8000_0003 : 32'h8000_0007);
    end
    exp_rv  = take_trap || take_ret;
    exp_rpc = take_ret ? {m_mepc, 2'b00} : {m_mtvec_base, 2'b00};
    if (take_trap && m_mtvec_mode == 2'b01 && cause[31]) begin
      exp_rpc = exp_rpc + {cause[29:0], 2'b00};
    end
    // software write wins over a same-cycle trap
    if (sw_wen) begin
      case (csr_addr)
        12'h300: {m_mpie, m_mstatus_mie} = {csr_wdata[7], csr_wdata[3]};
        12'h304: m_mie = {csr_wdata[11], csr_wdata[7], csr_wdata[3]};
        12'h305: {m_mtvec_base, m_mtvec_mode} = {csr_wdata[31:2], 1'b0, csr_wdata[0]};
        12'h340: m_mscratch = csr_wdata;
        12'h341: m_mepc = csr_wdata[31:2];
        default: ;
      endcase
    end else if (take_trap) begin
      m_mpie         = m_mstatus_mie;
      m_mstatus_mie  = 1'b0;
      m_mepc         = exc_pc;
      m_mcause       = cause;
      m_mcause_known = 1'b1;
    end else if (take_ret) begin
      m_mstatus_mie = m_mpie;
      m_mpie        = 1'b1;
    end
    @(negedge clk);
  endtask

  task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
    set_idle();
    csr_wen   = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    run_cycle();
  endtask

  task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
    set_idle();
    csr_ren  = 1'b1;
    csr_addr = addr;
    run_cycle();
    data = last_rdata;
  endtask

  // called right after the event cycle, counts cycles up to the pulse
  task automatic wait_redirect(output int lat);
    lat = 1;
    set_idle();
    while (redirect_valid !== 1'b1 && lat < REDIRECT_TIMEOUT) begin
      run_cycle();
      lat++;
    end
    if (redirect_valid !== 1'b1) begin
      timeouts++;
      $display("no redirect_valid pulse within %0d cycles at %0t", REDIRECT_TIMEOUT, $time);
    end
  endtask

  task automatic run_random(input int cycles, input int wen_pct, input int exc_pct,
                            input int mret_pct);
    logic [31:0] r;
    repeat (cycles) begin
      r             = $urandom();
      csr_ren       = r[1:0] != 2'b00;
      csr_wen       = $urandom_range(0, 99) < wen_pct;
      csr_addr      = pick_addr();
      csr_wdata     = $urandom();
      stall_n       = $urandom_range(0, 4) != 0;
      exc_valid     = $urandom_range(0, 99) < exc_pct;
      exc_cause     = {28'h0, r[5:2]};
      exc_pc        = random_pc();
      mret          = $urandom_range(0, 99) < mret_pct;
      mextern_int   = r[8] & r[9];
      mtimer_int    = r[10] & r[11];
      msoftware_int = r[12] & r[13];
      run_cycle();
    end
  endtask

  initial begin
    int unsigned             seed_val;
    int                      lat;
    logic [31:0]             rd;
    logic [`CORE_PC_LEN-1:0] pc_sel;
    seed_val = $urandom(37334);
    {checks, errors, timeouts} = '0;
    {m_mstatus_mie, m_mpie, m_mie, m_mtvec_base, m_mtvec_mode} = '0;
    {m_mscratch, m_mepc, m_mcause, m_mcause_known, exp_rv, exp_rpc} = '0;
    rst_sync = 1'b1;
    set_idle();
    {csr_addr, csr_wdata, exc_cause, exc_pc} = '0;
    {mextern_int, mtimer_int, msoftware_int} = 3'b000;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_sync = 1'b0;

    // reset values, cycle counter, payload registers
    read_csr(12'h300, rd);
    read_csr(12'h304, rd);
    read_csr(12'h305, rd);
    read_csr(12'hB00, rd);
    read_csr(12'hB80, rd);
    write_csr(12'h340, 32'h5A5A_0001);
    write_csr(12'h341, 32'h0000_1234);
    write_csr(12'h305, 32'h0000_8000);
    write_csr(12'h300, 32'h0000_0008);

    // exception into a direct vector
    pc_sel = random_pc();
    set_idle();
    {exc_valid, exc_cause, exc_pc} = {1'b1, 32'd2, pc_sel};
    run_cycle();
    wait_redirect(lat);
    check_value("redirect latency", lat, 1);
    check_value("redirect_pc", redirect_pc, 32'h0000_8000);
    read_csr(12'h341, rd);
    check_value("mepc", rd, {pc_sel, 2'b00});
    read_csr(12'h342, rd);
    check_value("mcause", rd, 32'd2);
    read_csr(12'h300, rd);
    check_value("mstatus", rd, 32'h0000_0080);

    // mret back to the saved pc
    set_idle();
    mret = 1'b1;
    run_cycle();
    wait_redirect(lat);
    check_value("redirect_pc", redirect_pc, {pc_sel, 2'b00});
    read_csr(12'h300, rd);
    check_value("mstatus", rd, 32'h0000_0088);

    // exception and mret together
    set_idle();
    {exc_valid, mret, exc_cause, exc_pc} = {2'b11, 32'd5, random_pc()};
    run_cycle();
    wait_redirect(lat);
    check_value("redirect_pc", redirect_pc, 32'h0000_8000);
    read_csr(12'h342, rd);
    check_value("mcause", rd, 32'd5);

    // vectored interrupt, held off by a stall first
    write_csr(12'h305, 32'h2000_0001);
    write_csr(12'h304, 32'h0000_0888);
    write_csr(12'h300, 32'h0000_0008);
    set_idle();
    {stall_n, mtimer_int, msoftware_int, exc_pc} = {3'b011, 30'h0400_0010};
    run_cycle();
    set_idle();
    run_cycle();
    wait_redirect(lat);
    check_value("redirect_pc", redirect_pc, 32'h2000_000C);
    {mtimer_int, msoftware_int} = 2'b00;
    read_csr(12'h342, rd);
    check_value("mcause", rd, 32'h8000_0003);
    set_idle();
    mret = 1'b1;
    run_cycle();

    run_random(400, 30, 0, 0);
    run_random(1200, 15, 4, 4);
    set_idle();
    run_cycle();

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
